//--- include/lc3b_config.svh
// LC-3b sizing macros fixed by the ISA and not meant to be changed
`ifndef LC3B_CONFIG_SVH
`define LC3B_CONFIG_SVH

// Data and address width
`define LC3B_WORD_W 16

// Architectural register count
`define LC3B_NUM_REGS 8

// First fetch address after reset
`define LC3B_RESET_PC 16'h0000

// SHF amount field width
`define LC3B_SHAMT_W 4

`endif

//--- hw/lc3b_pkg.sv
// Shared LC-3b types where the instruction views assume a 16-bit word
`default_nettype none

`include "lc3b_config.svh"

package lc3b_pkg;

	typedef logic [`LC3B_WORD_W-1:0] lc3b_word;
	typedef logic [2:0] lc3b_reg;

	// Flags held as {n, z, p}
	typedef logic [2:0] lc3b_cc;

	typedef enum logic [3:0] {
		OP_BR   = 4'h0,
		OP_ADD  = 4'h1,
		OP_LDB  = 4'h2,
		OP_STB  = 4'h3,
		OP_JSR  = 4'h4,
		OP_AND  = 4'h5,
		OP_LDR  = 4'h6,
		OP_STR  = 4'h7,
		OP_RTI  = 4'h8,
		OP_NOT  = 4'h9,
		OP_LDI  = 4'ha,
		OP_STI  = 4'hb,
		OP_JMP  = 4'hc,
		OP_SHF  = 4'hd,
		OP_LEA  = 4'he,
		OP_TRAP = 4'hf
	} lc3b_opcode;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_AND,
		ALU_NOT,
		ALU_SHF,
		ALU_PASS_ADDR
	} lc3b_alu_op;

	typedef struct packed {
		lc3b_opcode opcode;
		lc3b_reg dr;
		lc3b_reg sr1;
		logic imm_flag;
		logic [1:0] rsvd;
		lc3b_reg sr2;
	} lc3b_instr_reg_t;

	// SHF reuses this view with imm_flag as A, imm5[4] as D
	typedef struct packed {
		lc3b_opcode opcode;
		lc3b_reg dr;
		lc3b_reg sr1;
		logic imm_flag;
		logic [4:0] imm5;
	} lc3b_instr_imm_t;

	typedef struct packed {
		lc3b_opcode opcode;
		logic n;
		logic z;
		logic p;
		logic [8:0] offset9;
	} lc3b_instr_br_t;

	typedef union packed {
		lc3b_instr_reg_t r;
		lc3b_instr_imm_t i;
		lc3b_instr_br_t b;
	} lc3b_instr_u;

	typedef struct packed {
		lc3b_alu_op alu_op;
		logic use_imm;
		logic writes_reg;
		logic sets_cc;
		logic is_br;
		logic is_jmp;
	} lc3b_ctrl_t;

endpackage

`default_nettype wire

//--- hw/lc3b_fetch.sv
// Fetch stage that trusts i_imem_rdata only while i_imem_resp is high for the current address
`timescale 1ns/1ps
`default_nettype none

`include "lc3b_config.svh"

module lc3b_fetch
(
	input wire logic i_clk,
	input wire logic i_reset,
	input wire logic i_imem_resp,
	input lc3b_pkg::lc3b_word i_imem_rdata,
	input wire logic i_redirect,
	input lc3b_pkg::lc3b_word i_target,
	output lc3b_pkg::lc3b_word o_imem_addr,
	output logic o_fd_valid,
	output lc3b_pkg::lc3b_word o_fd_instr,
	output lc3b_pkg::lc3b_word o_fd_pc2
);

	import lc3b_pkg::*;

	lc3b_word pc;
	lc3b_word pc_plus2;
	lc3b_word pc_next;
	logic load_pc;

	assign o_imem_addr = pc;
	assign pc_plus2 = pc + `LC3B_WORD_W'(2);

	// Redirect wins over a pending response
	assign pc_next = i_redirect ? i_target : pc_plus2;
	assign load_pc = i_redirect || i_imem_resp;

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			pc <= `LC3B_RESET_PC;
		else if (load_pc)
			pc <= pc_next;
	end

	always_ff @(posedge i_clk)
	begin
		if (i_reset || i_redirect)
			o_fd_valid <= 1'b0;
		else
			o_fd_valid <= i_imem_resp;
	end

	always_ff @(posedge i_clk)
	begin
		if (i_imem_resp)
		begin
			o_fd_instr <= i_imem_rdata;
			o_fd_pc2 <= pc_plus2;
		end
	end

endmodule

`default_nettype wire

//--- hw/lc3b_regfile.sv
// Register file with write-through so a same-cycle read sees the incoming data
`timescale 1ns/1ps
`default_nettype none

`include "lc3b_config.svh"

module lc3b_regfile
(
	input wire logic i_clk,
	input wire logic i_reset,
	input wire logic i_we,
	input lc3b_pkg::lc3b_reg i_dest,
	input lc3b_pkg::lc3b_word i_data,
	input lc3b_pkg::lc3b_reg i_src_a,
	input lc3b_pkg::lc3b_reg i_src_b,
	output lc3b_pkg::lc3b_word o_a,
	output lc3b_pkg::lc3b_word o_b
);

	import lc3b_pkg::*;

	lc3b_word regs [`LC3B_NUM_REGS];

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			regs <= '{default: '0};
		else if (i_we)
			regs[i_dest] <= i_data;
	end

	assign o_a = (i_we && i_dest == i_src_a) ? i_data : regs[i_src_a];
	assign o_b = (i_we && i_dest == i_src_b) ? i_data : regs[i_src_b];

endmodule

`default_nettype wire

//--- hw/lc3b_decode.sv
// Decode stage that turns every opcode outside ADD AND NOT SHF LEA BR JMP into a bubble
`timescale 1ns/1ps
`default_nettype none

module lc3b_decode
(
	input wire logic i_clk,
	input wire logic i_reset,
	input wire logic i_flush,
	input wire logic i_fd_valid,
	input lc3b_pkg::lc3b_word i_fd_instr,
	input lc3b_pkg::lc3b_word i_fd_pc2,
	input wire logic i_wb_we,
	input lc3b_pkg::lc3b_reg i_wb_dest,
	input lc3b_pkg::lc3b_word i_wb_data,
	output logic o_de_valid,
	output lc3b_pkg::lc3b_word o_de_pc2,
	output lc3b_pkg::lc3b_instr_u o_de_instr,
	output lc3b_pkg::lc3b_ctrl_t o_de_ctrl,
	output lc3b_pkg::lc3b_word o_de_op_a,
	output lc3b_pkg::lc3b_word o_de_op_b,
	output lc3b_pkg::lc3b_reg o_de_src_a,
	output lc3b_pkg::lc3b_reg o_de_src_b
);

	import lc3b_pkg::*;

	lc3b_instr_u instr;
	lc3b_ctrl_t ctrl;
	logic supported;
	lc3b_reg src_a;
	lc3b_reg src_b;
	lc3b_word rf_a;
	lc3b_word rf_b;

	assign instr = i_fd_instr;

	always_comb
	begin
		ctrl = '0;
		supported = 1'b1;
		case (instr.r.opcode)
			OP_ADD, OP_AND:
			begin
				ctrl.alu_op = (instr.r.opcode == OP_ADD) ? ALU_ADD : ALU_AND;
				ctrl.use_imm = instr.r.imm_flag;
				ctrl.writes_reg = 1'b1;
				ctrl.sets_cc = 1'b1;
			end
			OP_NOT, OP_SHF:
			begin
				ctrl.alu_op = (instr.r.opcode == OP_NOT) ? ALU_NOT : ALU_SHF;
				ctrl.writes_reg = 1'b1;
				ctrl.sets_cc = 1'b1;
			end
			OP_LEA:
			begin
				// LC-3b LEA leaves the codes alone
				ctrl.alu_op = ALU_PASS_ADDR;
				ctrl.writes_reg = 1'b1;
			end
			OP_BR:
				ctrl.is_br = 1'b1;
			OP_JMP:
				ctrl.is_jmp = 1'b1;
			default:
				supported = 1'b0;
		endcase
	end

	// BaseR sits in the sr1 field for JMP
	assign src_a = instr.r.sr1;
	assign src_b = ctrl.is_jmp ? instr.r.sr1 : instr.r.sr2;

	lc3b_regfile regfile_i
	(
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_we(i_wb_we),
		.i_dest(i_wb_dest),
		.i_data(i_wb_data),
		.i_src_a(src_a),
		.i_src_b(src_b),
		.o_a(rf_a),
		.o_b(rf_b)
	);

	always_ff @(posedge i_clk)
	begin
		if (i_reset || i_flush)
			o_de_valid <= 1'b0;
		else
			o_de_valid <= i_fd_valid && supported;
	end

	always_ff @(posedge i_clk)
	begin
		o_de_pc2 <= i_fd_pc2;
		o_de_instr <= instr;
		o_de_ctrl <= ctrl;
		o_de_op_a <= rf_a;
		o_de_op_b <= rf_b;
		o_de_src_a <= src_a;
		o_de_src_b <= src_b;
	end

endmodule

`default_nettype wire

//--- hw/lc3b_execute.sv
// Execute stage where only the result stage forwards and branches read the forwarded codes
`timescale 1ns/1ps
`default_nettype none

`include "lc3b_config.svh"

module lc3b_execute
(
	input wire logic i_clk,
	input wire logic i_reset,
	input wire logic i_de_valid,
	input lc3b_pkg::lc3b_word i_de_pc2,
	input lc3b_pkg::lc3b_instr_u i_de_instr,
	input lc3b_pkg::lc3b_ctrl_t i_de_ctrl,
	input lc3b_pkg::lc3b_word i_de_op_a,
	input lc3b_pkg::lc3b_word i_de_op_b,
	input lc3b_pkg::lc3b_reg i_de_src_a,
	input lc3b_pkg::lc3b_reg i_de_src_b,
	input wire logic i_wb_we,
	input lc3b_pkg::lc3b_reg i_wb_dest,
	input lc3b_pkg::lc3b_word i_wb_data,
	input lc3b_pkg::lc3b_cc i_cc_fwd,
	output logic o_redirect,
	output lc3b_pkg::lc3b_word o_target,
	output logic o_ex_valid,
	output lc3b_pkg::lc3b_reg o_ex_dest,
	output lc3b_pkg::lc3b_word o_ex_result,
	output logic o_ex_sets_cc
);

	import lc3b_pkg::*;

	lc3b_word op_a;
	lc3b_word op_b_reg;
	lc3b_word op_b;
	lc3b_word imm5_sext;
	lc3b_word off9_sext;
	lc3b_word addr_sum;
	lc3b_word shift_out;
	lc3b_word alu_out;
	logic [`LC3B_SHAMT_W-1:0] shamt;
	logic br_taken;

	// Forward from the instruction retiring this cycle
	assign op_a = (i_wb_we && i_wb_dest == i_de_src_a) ? i_wb_data : i_de_op_a;
	assign op_b_reg = (i_wb_we && i_wb_dest == i_de_src_b) ? i_wb_data : i_de_op_b;

	assign imm5_sext = {{(`LC3B_WORD_W-5){i_de_instr.i.imm5[4]}}, i_de_instr.i.imm5};
	assign op_b = i_de_ctrl.use_imm ? imm5_sext : op_b_reg;

	// Word offset, so shifted left by one
	assign off9_sext = {{(`LC3B_WORD_W-10){i_de_instr.b.offset9[8]}},
		i_de_instr.b.offset9, 1'b0};
	assign addr_sum = i_de_pc2 + off9_sext;

	assign shamt = i_de_instr.i.imm5[`LC3B_SHAMT_W-1:0];

	always_comb
	begin
		if (!i_de_instr.i.imm5[4])
			shift_out = op_a << shamt;
		else if (!i_de_instr.i.imm_flag)
			shift_out = op_a >> shamt;
		else
			shift_out = lc3b_word'($signed(op_a) >>> shamt);
	end

	always_comb
	begin
		case (i_de_ctrl.alu_op)
			ALU_ADD:
				alu_out = op_a + op_b;
			ALU_AND:
				alu_out = op_a & op_b;
			ALU_NOT:
				alu_out = ~op_a;
			ALU_SHF:
				alu_out = shift_out;
			ALU_PASS_ADDR:
				alu_out = addr_sum;
			default:
				alu_out = '0;
		endcase
	end

	assign br_taken = |({i_de_instr.b.n, i_de_instr.b.z, i_de_instr.b.p} & i_cc_fwd);

	assign o_redirect = i_de_valid && ((i_de_ctrl.is_br && br_taken) || i_de_ctrl.is_jmp);
	assign o_target = i_de_ctrl.is_jmp ? op_a : addr_sum;

	// Branches and JMP retire nothing, so valid here means a register write
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_ex_valid <= 1'b0;
		else
			o_ex_valid <= i_de_valid && i_de_ctrl.writes_reg;
	end

	always_ff @(posedge i_clk)
	begin
		o_ex_dest <= i_de_instr.r.dr;
		o_ex_result <= alu_out;
		o_ex_sets_cc <= i_de_ctrl.sets_cc;
	end

endmodule

`default_nettype wire

//--- hw/lc3b_result.sv
// Result stage that owns the condition codes and resets them to z
`timescale 1ns/1ps
`default_nettype none

module lc3b_result
(
	input wire logic i_clk,
	input wire logic i_reset,
	input wire logic i_ex_valid,
	input lc3b_pkg::lc3b_reg i_ex_dest,
	input lc3b_pkg::lc3b_word i_ex_result,
	input wire logic i_ex_sets_cc,
	output logic o_wb_valid,
	output lc3b_pkg::lc3b_reg o_wb_dest,
	output lc3b_pkg::lc3b_word o_wb_data,
	output lc3b_pkg::lc3b_cc o_wb_cc,
	output lc3b_pkg::lc3b_cc o_cc_fwd
);

	import lc3b_pkg::*;

	lc3b_cc cc_reg;
	lc3b_cc cc_gen;
	lc3b_cc cc_next;
	logic cc_load;

	always_comb
	begin
		if ($signed(i_ex_result) < 0)
			cc_gen = 3'b100;
		else if (i_ex_result == '0)
			cc_gen = 3'b010;
		else
			cc_gen = 3'b001;
	end

	assign cc_load = i_ex_valid && i_ex_sets_cc;
	assign cc_next = cc_load ? cc_gen : cc_reg;

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			cc_reg <= 3'b010;
		else if (cc_load)
			cc_reg <= cc_gen;
	end

	// Next-younger instruction sees the codes as updated here
	assign o_cc_fwd = cc_next;
	assign o_wb_cc = cc_next;

	assign o_wb_valid = i_ex_valid;
	assign o_wb_dest = i_ex_dest;
	assign o_wb_data = i_ex_result;

endmodule

`default_nettype wire

//--- hw/lc3b_core.sv
// LC-3b core top without a data port where an accepted word retires three cycles later
`timescale 1ns/1ps
`default_nettype none

module lc3b_core
(
	input wire logic i_clk,
	input wire logic i_reset,
	input wire logic i_imem_resp,
	input lc3b_pkg::lc3b_word i_imem_rdata,
	output lc3b_pkg::lc3b_word o_imem_addr,
	output logic o_wb_valid,
	output lc3b_pkg::lc3b_reg o_wb_dest,
	output lc3b_pkg::lc3b_word o_wb_data,
	output lc3b_pkg::lc3b_cc o_wb_cc
);

	import lc3b_pkg::*;

	logic fd_valid;
	lc3b_word fd_instr;
	lc3b_word fd_pc2;

	logic de_valid;
	lc3b_word de_pc2;
	lc3b_instr_u de_instr;
	lc3b_ctrl_t de_ctrl;
	lc3b_word de_op_a;
	lc3b_word de_op_b;
	lc3b_reg de_src_a;
	lc3b_reg de_src_b;

	logic redirect;
	lc3b_word target;

	logic ex_valid;
	lc3b_reg ex_dest;
	lc3b_word ex_result;
	logic ex_sets_cc;

	lc3b_cc cc_fwd;

	lc3b_fetch fetch_i
	(
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_imem_resp(i_imem_resp),
		.i_imem_rdata(i_imem_rdata),
		.i_redirect(redirect),
		.i_target(target),
		.o_imem_addr(o_imem_addr),
		.o_fd_valid(fd_valid),
		.o_fd_instr(fd_instr),
		.o_fd_pc2(fd_pc2)
	);

	lc3b_decode decode_i
	(
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_flush(redirect),
		.i_fd_valid(fd_valid),
		.i_fd_instr(fd_instr),
		.i_fd_pc2(fd_pc2),
		.i_wb_we(o_wb_valid),
		.i_wb_dest(o_wb_dest),
		.i_wb_data(o_wb_data),
		.o_de_valid(de_valid),
		.o_de_pc2(de_pc2),
		.o_de_instr(de_instr),
		.o_de_ctrl(de_ctrl),
		.o_de_op_a(de_op_a),
		.o_de_op_b(de_op_b),
		.o_de_src_a(de_src_a),
		.o_de_src_b(de_src_b)
	);

	lc3b_execute execute_i
	(
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_de_valid(de_valid),
		.i_de_pc2(de_pc2),
		.i_de_instr(de_instr),
		.i_de_ctrl(de_ctrl),
		.i_de_op_a(de_op_a),
		.i_de_op_b(de_op_b),
		.i_de_src_a(de_src_a),
		.i_de_src_b(de_src_b),
		.i_wb_we(o_wb_valid),
		.i_wb_dest(o_wb_dest),
		.i_wb_data(o_wb_data),
		.i_cc_fwd(cc_fwd),
		.o_redirect(redirect),
		.o_target(target),
		.o_ex_valid(ex_valid),
		.o_ex_dest(ex_dest),
		.o_ex_result(ex_result),
		.o_ex_sets_cc(ex_sets_cc)
	);

	lc3b_result result_i
	(
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_ex_valid(ex_valid),
		.i_ex_dest(ex_dest),
		.i_ex_result(ex_result),
		.i_ex_sets_cc(ex_sets_cc),
		.o_wb_valid(o_wb_valid),
		.o_wb_dest(o_wb_dest),
		.o_wb_data(o_wb_data),
		.o_wb_cc(o_wb_cc),
		.o_cc_fwd(cc_fwd)
	);

endmodule

`default_nettype wire

//--- tests/lc3b_core_tb.sv
// Testbench for lc3b_core with a 64-word instruction memory, so programs must stay below byte 128
`timescale 1ns/1ps
`default_nettype none

`include "lc3b_config.svh"

module lc3b_core_tb;

	import lc3b_pkg::*;

	localparam int NUM_PROGS = 5;
	localparam int MAX_PROG_LEN = 41;
	localparam int WATCHDOG_CYCLES = NUM_PROGS * (MAX_PROG_LEN * 40 + 60);
	localparam lc3b_word HALT = 16'h0fff;

	logic clk;
	logic rst;
	logic imem_resp;
	lc3b_word imem_rdata;
	lc3b_word imem_addr;
	logic wb_valid;
	lc3b_reg wb_dest;
	lc3b_word wb_data;
	lc3b_cc wb_cc;

	lc3b_word mem [64];
	lc3b_word m_pc;
	lc3b_word m_regs [8];
	lc3b_cc m_cc;
	logic fetch_en;
	logic rand_en;
	logic [31:0] gen_state;
	logic [31:0] delay_state;
	int prog_len;
	int wb_count;

	lc3b_core lc3b_core_i
	(
		.i_clk(clk),
		.i_reset(rst),
		.i_imem_resp(imem_resp),
		.i_imem_rdata(imem_rdata),
		.o_imem_addr(imem_addr),
		.o_wb_valid(wb_valid),
		.o_wb_dest(wb_dest),
		.o_wb_data(wb_data),
		.o_wb_cc(wb_cc)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#10 clk = ~clk;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic lc3b_word enc_reg(lc3b_opcode op, lc3b_reg dr, lc3b_reg sr1, lc3b_reg sr2);
		return {op, dr, sr1, 3'b000, sr2};
	endfunction

	function automatic lc3b_word enc_imm(lc3b_opcode op, lc3b_reg dr, lc3b_reg sr1,
		logic [4:0] imm);
		return {op, dr, sr1, 1'b1, imm};
	endfunction

	function automatic lc3b_word enc_not(lc3b_reg dr, lc3b_reg sr);
		return {OP_NOT, dr, sr, 6'h3f};
	endfunction

	function automatic lc3b_word enc_shf(lc3b_reg dr, lc3b_reg sr, logic arith, logic right,
		logic [3:0] amt);
		return {OP_SHF, dr, sr, arith, right, amt};
	endfunction

	function automatic lc3b_word enc_lea(lc3b_reg dr, logic [8:0] off);
		return {OP_LEA, dr, off};
	endfunction

	function automatic lc3b_word enc_br(logic [2:0] nzp, logic [8:0] off);
		return {OP_BR, nzp, off};
	endfunction

	function automatic lc3b_word enc_jmp(lc3b_reg base);
		return {OP_JMP, 3'b000, base, 6'h00};
	endfunction

	// One ISA step on the model state; returns 1 when a register is written
	function automatic logic model_step(output lc3b_reg dest, output lc3b_word data,
		output lc3b_cc cc);
		lc3b_word ir;
		lc3b_word pc2;
		lc3b_word a;
		lc3b_word b;
		lc3b_word off;
		logic wr;
		logic upd;
		ir = mem[m_pc[6:1]];
		pc2 = m_pc + 16'd2;
		m_pc = pc2;
		a = m_regs[ir[8:6]];
		b = ir[5] ? {{11{ir[4]}}, ir[4:0]} : m_regs[ir[2:0]];
		off = {{6{ir[8]}}, ir[8:0], 1'b0};
		dest = ir[11:9];
		data = '0;
		wr = 1'b1;
		upd = 1'b1;
		case (lc3b_opcode'(ir[15:12]))
			OP_ADD: data = a + b;
			OP_AND: data = a & b;
			OP_NOT: data = ~a;
			OP_SHF:
			begin
				if (!ir[4])
					data = a << ir[3:0];
				else if (!ir[5])
					data = a >> ir[3:0];
				else
					data = lc3b_word'($signed(a) >>> ir[3:0]);
			end
			OP_LEA:
			begin
				data = pc2 + off;
				upd = 1'b0;
			end
			OP_BR:
			begin
				wr = 1'b0;
				upd = 1'b0;
				if ((ir[11:9] & m_cc) != 3'b000)
					m_pc = pc2 + off;
			end
			OP_JMP:
			begin
				wr = 1'b0;
				upd = 1'b0;
				m_pc = a;
			end
			default:
			begin
				wr = 1'b0;
				upd = 1'b0;
			end
		endcase
		if (wr)
			m_regs[dest] = data;
		if (upd)
			m_cc = data[15] ? 3'b100 : ((data == '0) ? 3'b010 : 3'b001);
		cc = m_cc;
		return wr;
	endfunction

	task automatic reset_model();
		m_pc = `LC3B_RESET_PC;
		for (int r = 0; r < 8; r++)
			m_regs[r] = '0;
		m_cc = 3'b010;
	endtask

	task automatic stop_with_failure(string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic check_bit(string name, logic got, logic exp);
		if (got !== exp)
			stop_with_failure($sformatf("CHECK FAILED at %0t: %s got %0b expected %0b",
				$time, name, got, exp));
	endtask

	task automatic check_reg(string name, lc3b_reg got, lc3b_reg exp);
		if (got !== exp)
			stop_with_failure($sformatf("CHECK FAILED at %0t: %s got R%0d expected R%0d",
				$time, name, got, exp));
	endtask

	task automatic check_word(string name, lc3b_word got, lc3b_word exp);
		if (got !== exp)
			stop_with_failure($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
				$time, name, got, exp));
	endtask

	task automatic check_cc(string name, lc3b_cc got, lc3b_cc exp);
		if (got !== exp)
			stop_with_failure($sformatf("CHECK FAILED at %0t: %s got %b expected %b",
				$time, name, got, exp));
	endtask

	task automatic put(lc3b_word w);
		mem[prog_len] = w;
		prog_len++;
	endtask

	task automatic build_random(int n);
		lc3b_reg dr;
		lc3b_reg s1;
		lc3b_reg s2;
		int k;
		for (int i = 0; i < n; i++)
		begin
			gen_state = lcg_next(gen_state);
			dr = gen_state[12:10];
			s1 = gen_state[15:13];
			s2 = gen_state[18:16];
			case (gen_state[30:28])
				3'd0: put(enc_reg(OP_ADD, dr, s1, s2));
				3'd1: put(enc_imm(OP_ADD, dr, s1, gen_state[23:19]));
				3'd2: put(enc_imm(OP_AND, dr, s1, gen_state[23:19]));
				3'd3: put(enc_reg(OP_AND, dr, s1, s2));
				3'd4: put(enc_not(dr, s1));
				3'd5: put(enc_shf(dr, s1, gen_state[24], gen_state[25], gen_state[23:20]));
				3'd6: put(enc_lea(dr, gen_state[27:19]));
				default:
				begin
					// Forward only, never past the final halt
					k = gen_state[9:8];
					if (i + 1 + k > n)
						k = 0;
					put(enc_br(gen_state[26:24], 9'(k)));
				end
			endcase
		end
		put(HALT);
	endtask

	task automatic load_program(int id);
		for (int a = 0; a < 64; a++)
			mem[a] = enc_br(3'b000, 9'(a));
		prog_len = 0;
		case (id)
			0:
			begin
				put(enc_imm(OP_ADD, 1, 0, 5'd5));
				put(enc_imm(OP_ADD, 2, 1, 5'h1d));
				put(enc_reg(OP_ADD, 3, 1, 2));
				put(enc_imm(OP_AND, 4, 3, 5'd6));
				put(enc_not(5, 4));
				put(enc_reg(OP_AND, 6, 5, 3));
				put(enc_reg(OP_ADD, 7, 6, 5));
				put(enc_imm(OP_AND, 1, 7, 5'd0));
				put(enc_reg(OP_ADD, 2, 2, 2));
				put(HALT);
			end
			1:
			begin
				put(enc_imm(OP_ADD, 1, 0, 5'h19));
				put(enc_shf(2, 1, 1'b0, 1'b0, 4'd3));
				put(enc_shf(3, 1, 1'b0, 1'b1, 4'd4));
				put(enc_shf(4, 1, 1'b1, 1'b1, 4'd2));
				put(enc_shf(5, 2, 1'b1, 1'b1, 4'd15));
				put(enc_lea(6, 9'd20));
				put(enc_lea(7, 9'h1fd));
				put(enc_shf(1, 6, 1'b0, 1'b0, 4'd0));
				put(HALT);
			end
			2:
			begin
				put(enc_imm(OP_ADD, 1, 0, 5'd4));
				put(enc_imm(OP_ADD, 2, 0, 5'd0));
				put(enc_imm(OP_ADD, 2, 2, 5'd3));
				put(enc_imm(OP_ADD, 1, 1, 5'h1f));
				put(enc_br(3'b001, 9'h1fd));
				put(enc_br(3'b010, 9'd1));
				put(enc_imm(OP_ADD, 3, 0, 5'd15));
				put(enc_imm(OP_ADD, 4, 2, 5'h14));
				put(enc_br(3'b100, 9'd1));
				put(enc_imm(OP_ADD, 5, 4, 5'h1f));
				put(enc_br(3'b100, 9'd1));
				put(enc_imm(OP_ADD, 3, 0, 5'd7));
				put(enc_imm(OP_ADD, 6, 5, 5'd2));
				put(HALT);
			end
			3:
			begin
				put(enc_lea(1, 9'd4));
				put(enc_jmp(1));
				put(enc_imm(OP_ADD, 2, 0, 5'd1));
				put(enc_imm(OP_ADD, 3, 0, 5'd2));
				put(HALT);
				put(enc_imm(OP_ADD, 4, 0, 5'd9));
				put(enc_reg(OP_ADD, 5, 4, 4));
				put(enc_jmp(5));
				put(enc_imm(OP_ADD, 6, 0, 5'h1f));
				put(enc_imm(OP_ADD, 7, 5, 5'd1));
				put(HALT);
			end
			default:
				build_random(MAX_PROG_LEN - 1);
		endcase
	endtask

	function automatic int count_writes();
		lc3b_reg d;
		lc3b_word v;
		lc3b_cc c;
		int n;
		int steps;
		n = 0;
		steps = 0;
		while (mem[m_pc[6:1]] != HALT && steps < 2000)
		begin
			if (model_step(d, v, c))
				n++;
			steps++;
		end
		return n;
	endfunction

	// Instruction memory answers on the falling edge
	always @(negedge clk)
	begin
		imem_rdata = mem[imem_addr[6:1]];
		if (!fetch_en)
			imem_resp = 1'b0;
		else if (rand_en)
		begin
			delay_state = lcg_next(delay_state);
			imem_resp = (delay_state[31:30] != 2'b00);
		end
		else
			imem_resp = 1'b1;
	end

	always @(posedge clk)
	begin : compare_wb
		lc3b_reg e_dest;
		lc3b_word e_data;
		lc3b_cc e_cc;
		logic found;
		int steps;
		if (rst)
			wb_count = 0;
		else if (wb_valid)
		begin
			found = 1'b0;
			steps = 0;
			while (!found && steps < 2000 && mem[m_pc[6:1]] != HALT)
			begin
				found = model_step(e_dest, e_data, e_cc);
				steps++;
			end
			if (!found)
				stop_with_failure("The core retired a register write that the model does not expect");
			check_reg("o_wb_dest", wb_dest, e_dest);
			check_word("o_wb_data", wb_data, e_data);
			check_cc("o_wb_cc", wb_cc, e_cc);
			wb_count++;
		end
	end

	task automatic run_program(int id, logic with_gaps, logic idle_check);
		int expected;
		rst = 1'b1;
		fetch_en <= 1'b0;
		rand_en <= with_gaps;
		load_program(id);
		reset_model();
		expected = count_writes();
		reset_model();
		repeat (10) @(negedge clk);
		rst = 1'b0;
		if (idle_check)
		begin
			repeat (5)
			begin
				@(negedge clk);
				check_bit("o_wb_valid", wb_valid, 1'b0);
				check_word("o_imem_addr", imem_addr, `LC3B_RESET_PC);
			end
		end
		fetch_en <= 1'b1;
		while (wb_count < expected)
			@(negedge clk);
		// Extra writes after the last expected one are caught by the compare process
		repeat (30) @(negedge clk);
	endtask

	initial
	begin
		#(WATCHDOG_CYCLES * 20);
		stop_with_failure("Watchdog expired: the core stopped retiring instructions");
	end

	initial
	begin
		rst = 1'b1;
		fetch_en = 1'b0;
		rand_en = 1'b0;
		imem_resp = 1'b0;
		imem_rdata = '0;
		gen_state = 32'hd9c6a014;
		delay_state = 32'hd9c6a014;
		wb_count = 0;
		prog_len = 0;
		run_program(0, 1'b0, 1'b1);
		run_program(1, 1'b0, 1'b0);
		run_program(2, 1'b0, 1'b0);
		run_program(3, 1'b0, 1'b0);
		run_program(4, 1'b1, 1'b0);
		$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire

//--- lc3b_core.f
+incdir+include
hw/lc3b_pkg.sv
hw/lc3b_fetch.sv
hw/lc3b_regfile.sv
hw/lc3b_decode.sv
hw/lc3b_execute.sv
hw/lc3b_result.sv
hw/lc3b_core.sv
tests/lc3b_core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the lc3b_core testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f lc3b_core.f --top-module lc3b_core_tb -o lc3b_sim

./obj_dir/lc3b_sim | tee sim.log

if grep -q "TEST OK" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi
